/* common/tcdm_pkg.sv */
// ------------------------------
// TCDM bank shared definitions
// Word geometry, request metadata
// and the atomic operation codes
// ------------------------------

package tcdm_pkg;

  // ------------------------------
  // Word geometry
  // ------------------------------
  parameter int unsigned DataWidth = 32;
  parameter int unsigned BeWidth   = DataWidth / 8;

  // ------------------------------
  // Request metadata
  // ------------------------------
  parameter int unsigned CoreIdWidth = 3;
  parameter int unsigned TagWidth    = 5;

  // Travels with every request, returned unchanged with the response
  typedef struct packed {
    logic [CoreIdWidth-1:0] core_id;
    logic [TagWidth-1:0]    tag;
  } meta_t;

  // RISC-V atomic operation codes as seen on the bank port
  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9,
    amo_lr   = 4'hA,
    amo_sc   = 4'hB
  } amo_op_e;

endpackage

/* logic/meta_spill_register.sv */
// ------------------------------
// Metadata buffer
// Two entries, no bypass
// ------------------------------

`timescale 1ns/1ps

module meta_spill_register (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            valid_i,
  output logic            ready_o,
  input  tcdm_pkg::meta_t data_i,
  output logic            valid_o,
  input  logic            ready_i,
  output tcdm_pkg::meta_t data_o
);

  tcdm_pkg::meta_t mem_q [2];
  logic [1:0]      count_q;
  logic            wr_ptr_q;
  logic            rd_ptr_q;
  logic            push;
  logic            pop;

  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      count_q  <= count_q + 2'(push) - 2'(pop);
      wr_ptr_q <= wr_ptr_q ^ push;
      rd_ptr_q <= rd_ptr_q ^ pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Upstream must never push into a full buffer
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_i |-> ready_o
  ) else $error("Metadata push while full");

endmodule

/* logic/rdata_fall_through_register.sv */
// ------------------------------
// Read data buffer
// Passes data through when empty,
// holds it until popped
// ------------------------------

`timescale 1ns/1ps

module rdata_fall_through_register #(
  parameter int unsigned Width = tcdm_pkg::DataWidth
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  logic             full_q;
  logic [Width-1:0] data_q;

  assign ready_o = ~full_q;
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= ~ready_i;
    end else begin
      // Keep it only when not taken in passing
      full_q <= valid_i & ~ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i) begin
      data_q <= data_i;
    end
  end

endmodule

/* logic/sram_bank.sv */
// ------------------------------
// SRAM bank model
// Single port, byte enables,
// one cycle read latency
// ------------------------------

`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned AddrWidth = 8
) (
  input  logic                           clk_i,
  input  logic                           req_i,
  input  logic                           write_i,
  input  logic [AddrWidth-1:0]           addr_i,
  input  logic [tcdm_pkg::DataWidth-1:0] wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   be_i,
  output logic [tcdm_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned NumWords = 2 ** AddrWidth;

  logic [tcdm_pkg::DataWidth-1:0] mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      // Only enabled bytes change
      for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end else if (req_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* tcdm_adapter/amo_alu.sv */
// ------------------------------
// AMO ALU
// New memory word from old word and operand
// ------------------------------

`timescale 1ns/1ps

module amo_alu (
  input  tcdm_pkg::amo_op_e              op_i,
  input  logic [tcdm_pkg::DataWidth-1:0] mem_i,
  input  logic [tcdm_pkg::DataWidth-1:0] operand_i,
  output logic [tcdm_pkg::DataWidth-1:0] result_o
);

  localparam int unsigned Width = tcdm_pkg::DataWidth;

  logic             is_signed;
  logic             do_sub;
  logic             mem_less;
  logic [Width:0]   adder_a, adder_b, adder_sum;

  // Signed compares extend with the sign bit, unsigned with zero
  assign is_signed = op_i inside {tcdm_pkg::amo_max, tcdm_pkg::amo_min};
  assign do_sub    = op_i inside {tcdm_pkg::amo_max, tcdm_pkg::amo_min,
                                  tcdm_pkg::amo_maxu, tcdm_pkg::amo_minu};

  // One shared adder, subtraction by inverting b with carry in
  assign adder_a   = {is_signed & mem_i[Width-1], mem_i};
  assign adder_b   = {is_signed & operand_i[Width-1], operand_i} ^ {(Width+1){do_sub}};
  assign adder_sum = adder_a + adder_b + (Width+1)'(do_sub);

  // Sign of mem - operand
  assign mem_less = adder_sum[Width];

  always_comb begin
    unique case (op_i)
      tcdm_pkg::amo_swap: result_o = operand_i;
      tcdm_pkg::amo_add:  result_o = adder_sum[Width-1:0];
      tcdm_pkg::amo_and:  result_o = mem_i & operand_i;
      tcdm_pkg::amo_or:   result_o = mem_i | operand_i;
      tcdm_pkg::amo_xor:  result_o = mem_i ^ operand_i;
      tcdm_pkg::amo_max,
      tcdm_pkg::amo_maxu: result_o = mem_less ? operand_i : mem_i;
      tcdm_pkg::amo_min,
      tcdm_pkg::amo_minu: result_o = mem_less ? mem_i : operand_i;
      // Not a read-modify-write
      default:            result_o = '0;
    endcase
  end

endmodule

/* tcdm_adapter/lrsc_reservation.sv */
// ------------------------------
// LR/SC reservation
// Single reservation for the bank,
// decides SC success per request
// ------------------------------

`timescale 1ns/1ps

module lrsc_reservation #(
  parameter int unsigned AddrWidth  = 8,
  parameter bit          LrScEnable = 1'b1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              accept_i,
  input  tcdm_pkg::amo_op_e                 amo_i,
  input  logic                              write_i,
  input  logic [AddrWidth-1:0]              addr_i,
  input  logic [tcdm_pkg::CoreIdWidth-1:0]  core_i,
  output logic                              sc_success_o,
  output logic                              sc_o
);

  logic                             res_valid_q, res_valid_d;
  logic [AddrWidth-1:0]             res_addr_q, res_addr_d;
  logic [tcdm_pkg::CoreIdWidth-1:0] res_core_q, res_core_d;
  logic                             is_rmw;

  assign is_rmw = ~(amo_i inside {tcdm_pkg::amo_none, tcdm_pkg::amo_lr, tcdm_pkg::amo_sc});

  always_comb begin
    res_valid_d  = res_valid_q;
    res_addr_d   = res_addr_q;
    res_core_d   = res_core_q;
    sc_success_o = 1'b0;
    if (accept_i) begin
      // LR takes the reservation if free or already ours
      if (amo_i == tcdm_pkg::amo_lr && (!res_valid_q || res_core_q == core_i)) begin
        res_valid_d = LrScEnable;
        res_addr_d  = addr_i;
        res_core_d  = core_i;
      end
      // Write or AMO by another core breaks it
      if (res_core_q != core_i && res_addr_q == addr_i && (write_i || is_rmw)) begin
        res_valid_d = 1'b0;
      end
      // SC from the holder always consumes the reservation
      if (res_valid_q && amo_i == tcdm_pkg::amo_sc && res_core_q == core_i) begin
        res_valid_d  = 1'b0;
        sc_success_o = (res_addr_q == addr_i) & LrScEnable;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
      sc_o        <= 1'b0;
    end else begin
      res_valid_q <= res_valid_d;
      // Marks the next response as an SC result
      sc_o        <= accept_i & (amo_i == tcdm_pkg::amo_sc) & LrScEnable;
    end
  end

  always_ff @(posedge clk_i) begin
    res_addr_q <= res_addr_d;
    res_core_q <= res_core_d;
  end

endmodule

/* tcdm_adapter/tcdm_adapter.sv */
// ------------------------------
// TCDM bank adapter
// Turns valid/ready requests into SRAM strobes,
// returns metadata with read data and runs
// AMOs and LR/SC inside the bank
// ------------------------------

`timescale 1ns/1ps

module tcdm_adapter #(
  parameter int unsigned AddrWidth   = 8,
  parameter bit          RegisterAmo = 1'b0,
  parameter bit          LrScEnable  = 1'b1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Request from the interconnect
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  logic [AddrWidth-1:0]              in_address_i,
  input  tcdm_pkg::amo_op_e                 in_amo_i,
  input  logic                              in_write_i,
  input  logic [tcdm_pkg::DataWidth-1:0]    in_wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]      in_be_i,
  input  tcdm_pkg::meta_t                   in_meta_i,
  // Response to the interconnect
  output logic                              in_valid_o,
  input  logic                              in_ready_i,
  output logic [tcdm_pkg::DataWidth-1:0]    in_rdata_o,
  output tcdm_pkg::meta_t                   in_meta_o,
  // SRAM strobes
  output logic                              out_req_o,
  output logic                              out_write_o,
  output logic [AddrWidth-1:0]              out_addr_o,
  output logic [tcdm_pkg::DataWidth-1:0]    out_wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0]      out_be_o,
  input  logic [tcdm_pkg::DataWidth-1:0]    out_rdata_i
);

  typedef enum logic [1:0] {
    idle,
    do_amo,
    write_back
  } state_e;

  state_e state_q, state_d;

  logic meta_valid, meta_ready;
  logic rdata_valid, rdata_ready;
  logic pop_resp;
  logic accept;
  logic is_rmw;
  logic load_amo;
  logic out_gnt_q;
  logic sc_success, sc_success_q;
  logic sc_q;

  logic [tcdm_pkg::DataWidth-1:0] resp_data;
  logic [tcdm_pkg::DataWidth-1:0] amo_result, amo_result_q;
  logic [tcdm_pkg::DataWidth-1:0] operand_q;
  logic [AddrWidth-1:0]           addr_q;
  tcdm_pkg::amo_op_e              amo_op_q;

  // ------------------------------
  // Response path
  // ------------------------------
  // Loads, LR, SC and AMOs all answer, stores stay silent
  meta_spill_register i_meta_register (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(accept & ~in_write_i),
    .ready_o(meta_ready),
    .data_i (in_meta_i),
    .valid_o(meta_valid),
    .ready_i(pop_resp),
    .data_o (in_meta_o)
  );

  // Read data lands one cycle after the strobe, held under back-pressure
  rdata_fall_through_register #(
    .Width(tcdm_pkg::DataWidth)
  ) i_rdata_register (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(out_gnt_q),
    .ready_o(rdata_ready),
    .data_i (resp_data),
    .valid_o(rdata_valid),
    .ready_i(pop_resp),
    .data_o (in_rdata_o)
  );

  // Metadata is always there first, read data completes the response
  assign in_valid_o = meta_valid & rdata_valid;
  assign pop_resp   = in_valid_o & in_ready_i;

  // Stall while a response waits or an AMO owns the SRAM
  assign in_ready_o = (state_q == idle) & meta_ready & ~(in_valid_o & ~in_ready_i);
  assign accept     = in_valid_i & in_ready_o;

  // SC answers 0 on success, 1 on failure
  assign resp_data = sc_q ? {{(tcdm_pkg::DataWidth-1){1'b0}}, ~sc_success_q} : out_rdata_i;

  // ------------------------------
  // LR/SC
  // ------------------------------
  lrsc_reservation #(
    .AddrWidth (AddrWidth),
    .LrScEnable(LrScEnable)
  ) i_reservation (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .amo_i       (in_amo_i),
    .write_i     (in_write_i),
    .addr_i      (in_address_i),
    .core_i      (in_meta_i.core_id),
    .sc_success_o(sc_success),
    .sc_o        (sc_q)
  );

  // ------------------------------
  // Atomics
  // ------------------------------
  assign is_rmw = ~(in_amo_i inside {tcdm_pkg::amo_none, tcdm_pkg::amo_lr, tcdm_pkg::amo_sc});

  // Old word straight from the SRAM in the do_amo cycle
  amo_alu i_amo_alu (
    .op_i     (amo_op_q),
    .mem_i    (out_rdata_i),
    .operand_i(operand_q),
    .result_o (amo_result)
  );

  always_comb begin
    state_d  = state_q;
    load_amo = 1'b0;
    // Default is the feed-through of the accepted request
    out_req_o   = accept;
    out_write_o = in_write_i | sc_success;
    out_addr_o  = in_address_i;
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;
    unique case (state_q)
      idle: begin
        if (accept && is_rmw) begin
          load_amo = 1'b1;
          state_d  = do_amo;
        end
      end
      do_amo, write_back: begin
        // Full-word write of the result, only once it is ready
        out_req_o   = !RegisterAmo || (state_q == write_back);
        out_write_o = 1'b1;
        out_addr_o  = addr_q;
        out_be_o    = '1;
        out_wdata_o = RegisterAmo ? amo_result_q : amo_result;
        state_d     = (RegisterAmo && state_q == do_amo) ? write_back : idle;
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= idle;
      out_gnt_q    <= 1'b0;
      sc_success_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Grant follows a read strobe or a successful SC by one cycle
      out_gnt_q    <= (out_req_o & ~out_write_o) | sc_success;
      sc_success_q <= sc_success;
    end
  end

  // AMO operands and the optional result slice
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      amo_op_q  <= in_amo_i;
      addr_q    <= in_address_i;
      operand_q <= in_wdata_i;
    end
    if (state_q == do_amo) begin
      amo_result_q <= amo_result;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // One outstanding response at most, so the data buffer has room
  a_gnt_room : assert property (
    @(posedge clk_i) disable iff (!rst_ni) out_gnt_q |-> rdata_ready
  ) else $error("Read grant while data buffer is full");

  // An accepted AMO closes the port while it owns the SRAM
  a_busy_stall : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (accept && is_rmw) |=> !in_ready_o
  ) else $error("Request accepted during AMO");

endmodule

/* logic/tcdm_bank_top.sv */
// ------------------------------
// TCDM bank top
// Adapter in front of its SRAM bank
// ------------------------------

`timescale 1ns/1ps

module tcdm_bank_top #(
  parameter int unsigned AddrWidth   = 8,
  parameter bit          RegisterAmo = 1'b0,
  parameter bit          LrScEnable  = 1'b1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Request side
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  input  logic [AddrWidth-1:0]           in_address_i,
  input  tcdm_pkg::amo_op_e              in_amo_i,
  input  logic                           in_write_i,
  input  logic [tcdm_pkg::DataWidth-1:0] in_wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   in_be_i,
  input  tcdm_pkg::meta_t                in_meta_i,
  // Response side
  output logic                           in_valid_o,
  input  logic                           in_ready_i,
  output logic [tcdm_pkg::DataWidth-1:0] in_rdata_o,
  output tcdm_pkg::meta_t                in_meta_o
);

  // SRAM strobes
  logic                           sram_req;
  logic                           sram_write;
  logic [AddrWidth-1:0]           sram_addr;
  logic [tcdm_pkg::DataWidth-1:0] sram_wdata;
  logic [tcdm_pkg::BeWidth-1:0]   sram_be;
  logic [tcdm_pkg::DataWidth-1:0] sram_rdata;

  tcdm_adapter #(
    .AddrWidth  (AddrWidth),
    .RegisterAmo(RegisterAmo),
    .LrScEnable (LrScEnable)
  ) i_tcdm_adapter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_address_i(in_address_i),
    .in_amo_i    (in_amo_i),
    .in_write_i  (in_write_i),
    .in_wdata_i  (in_wdata_i),
    .in_be_i     (in_be_i),
    .in_meta_i   (in_meta_i),
    .in_valid_o  (in_valid_o),
    .in_ready_i  (in_ready_i),
    .in_rdata_o  (in_rdata_o),
    .in_meta_o   (in_meta_o),
    .out_req_o   (sram_req),
    .out_write_o (sram_write),
    .out_addr_o  (sram_addr),
    .out_wdata_o (sram_wdata),
    .out_be_o    (sram_be),
    .out_rdata_i (sram_rdata)
  );

  sram_bank #(
    .AddrWidth(AddrWidth)
  ) i_sram_bank (
    .clk_i  (clk_i),
    .req_i  (sram_req),
    .write_i(sram_write),
    .addr_i (sram_addr),
    .wdata_i(sram_wdata),
    .be_i   (sram_be),
    .rdata_o(sram_rdata)
  );

endmodule

/* tests/tb_tcdm_bank_top.sv */
// ------------------------------
// TCDM bank testbench
// Table of loads, stores, AMOs and LR/SC
// under random response back-pressure
// ------------------------------

`timescale 1ns/1ps

module tb_tcdm_bank_top;

  localparam int unsigned AddrWidth   = 8;
  localparam int          ClkPeriod   = 10;
  localparam int          ResetCycles = 5;
  localparam int          NumEntries  = 39;

  // One row of the stimulus table
  typedef struct packed {
    tcdm_pkg::amo_op_e                op;
    bit                               write;
    logic [AddrWidth-1:0]             addr;
    logic [tcdm_pkg::DataWidth-1:0]   wdata;
    logic [tcdm_pkg::BeWidth-1:0]     be;
    logic [tcdm_pkg::CoreIdWidth-1:0] core;
    logic [tcdm_pkg::TagWidth-1:0]    tag;
    bit                               resp;
    logic [tcdm_pkg::DataWidth-1:0]   exp_rdata;
  } entry_t;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           in_valid_i;
  logic                           in_ready_o;
  logic [AddrWidth-1:0]           in_address_i;
  tcdm_pkg::amo_op_e              in_amo_i;
  logic                           in_write_i;
  logic [tcdm_pkg::DataWidth-1:0] in_wdata_i;
  logic [tcdm_pkg::BeWidth-1:0]   in_be_i;
  tcdm_pkg::meta_t                in_meta_i;
  logic                           in_valid_o;
  logic                           in_ready_i;
  logic [tcdm_pkg::DataWidth-1:0] in_rdata_o;
  tcdm_pkg::meta_t                in_meta_o;

  entry_t      stim [NumEntries];
  int          num_filled;
  int          errors;
  int          checks;
  int          pop_count;
  int          expected_resps;

  tcdm_bank_top #(
    .AddrWidth  (AddrWidth),
    .RegisterAmo(1'b0),
    .LrScEnable (1'b1)
  ) dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_address_i(in_address_i),
    .in_amo_i    (in_amo_i),
    .in_write_i  (in_write_i),
    .in_wdata_i  (in_wdata_i),
    .in_be_i     (in_be_i),
    .in_meta_i   (in_meta_i),
    .in_valid_o  (in_valid_o),
    .in_ready_i  (in_ready_i),
    .in_rdata_o  (in_rdata_o),
    .in_meta_o   (in_meta_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Every response handshake, expected or not
  always @(posedge clk_i) begin
    if (rst_ni && in_valid_o && in_ready_i) begin
      pop_count++;
    end
  end

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic add_entry(input tcdm_pkg::amo_op_e op, input bit write,
                           input logic [AddrWidth-1:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, input logic [2:0] core,
                           input bit resp, input logic [31:0] exp_rdata);
    if (num_filled < NumEntries) begin
      stim[num_filled].op        = op;
      stim[num_filled].write     = write;
      stim[num_filled].addr      = addr;
      stim[num_filled].wdata     = wdata;
      stim[num_filled].be        = be;
      stim[num_filled].core      = core;
      // Tag follows the row number
      stim[num_filled].tag       = 5'(num_filled);
      stim[num_filled].resp      = resp;
      stim[num_filled].exp_rdata = exp_rdata;
    end
    num_filled++;
  endtask

  task automatic add_store(input logic [AddrWidth-1:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, input logic [2:0] core);
    add_entry(tcdm_pkg::amo_none, 1'b1, addr, wdata, be, core, 1'b0, '0);
  endtask

  task automatic add_load(input logic [AddrWidth-1:0] addr, input logic [2:0] core,
                          input logic [31:0] exp_rdata);
    add_entry(tcdm_pkg::amo_none, 1'b0, addr, '0, 4'hF, core, 1'b1, exp_rdata);
  endtask

  // AMOs, LR and SC all go out as non-writes with a response
  task automatic add_atomic(input tcdm_pkg::amo_op_e op, input logic [AddrWidth-1:0] addr,
                            input logic [31:0] operand, input logic [2:0] core,
                            input logic [31:0] exp_rdata);
    add_entry(op, 1'b0, addr, operand, 4'hF, core, 1'b1, exp_rdata);
  endtask

  task automatic fill_table();
    // Plain and partial stores
    add_store(8'h10, 32'h1234_5678, 4'hF, 3'd0);
    add_load(8'h10, 3'd0, 32'h1234_5678);
    add_store(8'h10, 32'hAABB_CCDD, 4'h5, 3'd1);
    add_load(8'h10, 3'd1, 32'h12BB_56DD);
    // Swap and add, old word comes back
    add_store(8'h20, 32'h0000_0005, 4'hF, 3'd2);
    add_atomic(tcdm_pkg::amo_swap, 8'h20, 32'hCAFE_F00D, 3'd2, 32'h0000_0005);
    add_load(8'h20, 3'd2, 32'hCAFE_F00D);
    add_store(8'h21, 32'h7FFF_FFFF, 4'hF, 3'd3);
    add_atomic(tcdm_pkg::amo_add, 8'h21, 32'h0000_0001, 3'd3, 32'h7FFF_FFFF);
    add_load(8'h21, 3'd3, 32'h8000_0000);
    // Logic ops chained on one word
    add_store(8'h22, 32'hF0F0_FF00, 4'hF, 3'd4);
    add_atomic(tcdm_pkg::amo_and, 8'h22, 32'h0FF0_F0F0, 3'd4, 32'hF0F0_FF00);
    add_load(8'h22, 3'd4, 32'h00F0_F000);
    add_atomic(tcdm_pkg::amo_or, 8'h22, 32'h0000_000F, 3'd5, 32'h00F0_F000);
    add_atomic(tcdm_pkg::amo_xor, 8'h22, 32'hFFFF_FFFF, 3'd5, 32'h00F0_F00F);
    add_load(8'h22, 3'd5, 32'hFF0F_0FF0);
    // Signed against unsigned compares on negative values
    add_store(8'h23, 32'hFFFF_FFF0, 4'hF, 3'd6);
    add_atomic(tcdm_pkg::amo_max, 8'h23, 32'h0000_0003, 3'd6, 32'hFFFF_FFF0);
    add_atomic(tcdm_pkg::amo_maxu, 8'h23, 32'hFFFF_FFFE, 3'd6, 32'h0000_0003);
    add_atomic(tcdm_pkg::amo_min, 8'h23, 32'h0000_0007, 3'd7, 32'hFFFF_FFFE);
    add_atomic(tcdm_pkg::amo_minu, 8'h23, 32'h0000_0007, 3'd7, 32'hFFFF_FFFE);
    add_atomic(tcdm_pkg::amo_max, 8'h23, 32'h8000_0000, 3'd7, 32'h0000_0007);
    add_load(8'h23, 3'd7, 32'h0000_0007);
    // LR then SC, then SC without reservation
    add_store(8'h30, 32'h1111_1111, 4'hF, 3'd1);
    add_atomic(tcdm_pkg::amo_lr, 8'h30, 32'h0, 3'd1, 32'h1111_1111);
    add_atomic(tcdm_pkg::amo_sc, 8'h30, 32'h2222_2222, 3'd1, 32'h0);
    add_load(8'h30, 3'd1, 32'h2222_2222);
    add_atomic(tcdm_pkg::amo_sc, 8'h30, 32'h3333_3333, 3'd1, 32'h1);
    add_load(8'h30, 3'd0, 32'h2222_2222);
    // Store from core 3 breaks the reservation of core 2
    add_atomic(tcdm_pkg::amo_lr, 8'h30, 32'h0, 3'd2, 32'h2222_2222);
    add_store(8'h30, 32'h4444_4444, 4'hF, 3'd3);
    add_atomic(tcdm_pkg::amo_sc, 8'h30, 32'h5555_5555, 3'd2, 32'h1);
    add_load(8'h30, 3'd2, 32'h4444_4444);
    // SC from a non-holder fails and leaves the reservation
    add_store(8'h31, 32'h0000_0000, 4'hF, 3'd4);
    add_atomic(tcdm_pkg::amo_lr, 8'h31, 32'h0, 3'd4, 32'h0);
    add_atomic(tcdm_pkg::amo_sc, 8'h31, 32'h6666_6666, 3'd5, 32'h1);
    add_atomic(tcdm_pkg::amo_sc, 8'h31, 32'h7777_7777, 3'd4, 32'h0);
    add_load(8'h31, 3'd6, 32'h7777_7777);
    add_load(8'h10, 3'd7, 32'h12BB_56DD);
  endtask

  // ------------------------------
  // Driving and checking
  // ------------------------------
  function automatic logic random_bit();
    return 1'($urandom % 2);
  endfunction

  // No response may be pending before a new request
  task automatic check_silent(input int idx);
    checks++;
    assert (in_valid_o === 1'b0) else begin
      $display("Response showed up with nothing outstanding before entry %0d", idx);
      errors++;
    end
  endtask

  task automatic issue_request(input int idx);
    entry_t e;
    e = stim[idx];
    @(negedge clk_i);
    in_valid_i        = 1'b1;
    in_amo_i          = e.op;
    in_write_i        = e.write;
    in_address_i      = e.addr;
    in_wdata_i        = e.wdata;
    in_be_i           = e.be;
    in_meta_i.core_id = e.core;
    in_meta_i.tag     = e.tag;
    in_ready_i        = random_bit();
    #1;
    check_silent(idx);
    while (in_ready_o !== 1'b1) begin
      @(negedge clk_i);
      in_ready_i = random_bit();
      #1;
      check_silent(idx);
    end
    // Taken at the coming rising edge
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic collect_response(input int idx);
    entry_t                         e;
    tcdm_pkg::meta_t                exp_meta;
    tcdm_pkg::meta_t                held_meta;
    logic [tcdm_pkg::DataWidth-1:0] held_rdata;
    bit                             popped;
    bit                             first;
    e                = stim[idx];
    exp_meta.core_id = e.core;
    exp_meta.tag     = e.tag;
    popped           = 1'b0;
    first            = 1'b1;
    while (!popped) begin
      in_ready_i = random_bit();
      #1;
      checks++;
      assert (in_valid_o === 1'b1) else begin
        $display("Response for entry %0d is missing", idx);
        errors++;
      end
      if (first) begin
        // SRAM is busy with the write-back right after an AMO
        if (e.op inside {tcdm_pkg::amo_swap, tcdm_pkg::amo_add, tcdm_pkg::amo_and,
                         tcdm_pkg::amo_or, tcdm_pkg::amo_xor, tcdm_pkg::amo_max,
                         tcdm_pkg::amo_maxu, tcdm_pkg::amo_min, tcdm_pkg::amo_minu}) begin
          checks++;
          assert (in_ready_o === 1'b0) else begin
            $display("Fail in_ready_o entry %0d: expected %h, got %h", idx, 1'b0, in_ready_o);
            errors++;
          end
        end
      end else begin
        // Held response must not move
        checks++;
        assert (in_rdata_o === held_rdata && in_meta_o === held_meta) else begin
          $display("Response for entry %0d changed while held back", idx);
          errors++;
        end
      end
      held_rdata = in_rdata_o;
      held_meta  = in_meta_o;
      if (in_valid_o === 1'b1 && in_ready_i) begin
        popped = 1'b1;
        checks += 2;
        assert (in_rdata_o === e.exp_rdata) else begin
          $display("Fail in_rdata_o entry %0d: expected %h, got %h", idx, e.exp_rdata,
                   in_rdata_o);
          errors++;
        end
        assert (in_meta_o === exp_meta) else begin
          $display("Fail in_meta_o entry %0d: expected %h, got %h", idx, exp_meta, in_meta_o);
          errors++;
        end
      end else begin
        @(negedge clk_i);
      end
      first = 1'b0;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    in_valid_i     = 1'b0;
    in_address_i   = '0;
    in_amo_i       = tcdm_pkg::amo_none;
    in_write_i     = 1'b0;
    in_wdata_i     = '0;
    in_be_i        = '0;
    in_meta_i      = '0;
    in_ready_i     = 1'b0;
    num_filled     = 0;
    errors         = 0;
    checks         = 0;
    pop_count      = 0;
    expected_resps = 0;
    // One seed for the whole run
    void'($urandom(32'h3700));
    fill_table();
    checks++;
    assert (num_filled == NumEntries) else begin
      $display("Stimulus table holds %0d rows instead of %0d", num_filled, NumEntries);
      errors++;
    end
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    checks += 2;
    assert (in_valid_o === 1'b0) else begin
      $display("Fail in_valid_o after reset: expected %h, got %h", 1'b0, in_valid_o);
      errors++;
    end
    assert (in_ready_o === 1'b1) else begin
      $display("Fail in_ready_o after reset: expected %h, got %h", 1'b1, in_ready_o);
      errors++;
    end
    for (int i = 0; i < NumEntries; i++) begin
      issue_request(i);
      if (stim[i].resp) begin
        expected_resps++;
        collect_response(i);
      end
    end
    // Trailing cycles stay quiet
    in_ready_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      #1;
      check_silent(NumEntries);
    end
    checks++;
    assert (pop_count == expected_resps) else begin
      $display("Saw %0d responses where %0d were expected", pop_count, expected_resps);
      errors++;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Budget of reset plus 40 cycles per row
  initial begin
    #((ResetCycles + 40 * NumEntries) * ClkPeriod);
    $display("Watchdog expired before the table was done");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sources.f */
common/tcdm_pkg.sv
logic/meta_spill_register.sv
logic/rdata_fall_through_register.sv
logic/sram_bank.sv
tcdm_adapter/amo_alu.sv
tcdm_adapter/lrsc_reservation.sv
tcdm_adapter/tcdm_adapter.sv
logic/tcdm_bank_top.sv
tests/tb_tcdm_bank_top.sv
